// ==== Bender.yml ====
package:
  name: mdu_pipe

sources:
  - files:
      - source/mdu_cfg_pkg.sv
      - source/mdu_pipe_pkg.sv
      - source/mdu_credit_fifo.sv
      - source/mdu_op_decode.sv
      - source/mdu_multiplier.sv
      - source/mdu_divider.sv
      - source/mdu_result_stage.sv
      - source/mdu_pipe.sv
  - target: test
    files:
      - verif/mdu_pipe_tb.sv

// ==== files.f ====
source/mdu_cfg_pkg.sv
source/mdu_pipe_pkg.sv
source/mdu_credit_fifo.sv
source/mdu_op_decode.sv
source/mdu_multiplier.sv
source/mdu_divider.sv
source/mdu_result_stage.sv
source/mdu_pipe.sv
verif/mdu_pipe_tb.sv

// ==== source/mdu_cfg_pkg.sv ====
// Widths, credit depths and operation codes of the multiply/divide pipe
// Issue and writeback credit counts must match the issuer and the consumer
// Operation codes follow the RV32M funct3 order
`default_nettype none

package mdu_cfg_pkg;

  // ==========================================================
  // Datapath
  // ==========================================================
  localparam int XLEN = 32;
  localparam int PREG_W = 6;

  // ==========================================================
  // Credits and queues
  // ==========================================================
  // Input queue depth, also the issuer's starting credit count
  localparam int ISSUE_CREDITS = 4;
  // Writeback slots granted by the consumer after reset
  localparam int WB_CREDITS = 2;
  localparam int WB_QUEUE_DEPTH = 2;
  // Counter wide enough to hold WB_CREDITS
  localparam int WB_CNT_W = $clog2(WB_CREDITS + 1);

  // Restoring divider, one quotient bit per step
  localparam int DIV_STEPS = XLEN;
  localparam int DIV_CNT_W = $clog2(DIV_STEPS);

  typedef enum logic [2:0] {
    MDU_MUL    = 3'd0,
    MDU_MULH   = 3'd1,
    MDU_MULHSU = 3'd2,
    MDU_MULHU  = 3'd3,
    MDU_DIV    = 3'd4,
    MDU_DIVU   = 3'd5,
    MDU_REM    = 3'd6,
    MDU_REMU   = 3'd7
  } mdu_op_e;

endpackage

`default_nettype wire

// ==== source/mdu_credit_fifo.sv ====
// Credit-tracked queue, the writer must hold a credit for every push
// Pop data is the registered head, visible the cycle after the push
// credit_o pulses in the cycle of each pop that removes an entry
`timescale 1ns/1ps
`default_nettype none

module mdu_credit_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 2
) (
  input  wire logic     clk,
  input  wire logic     rst_n,
  input  wire logic     push_i,
  input  wire payload_t push_data_i,
  input  wire logic     pop_i,
  output payload_t      pop_data_o,
  output logic          empty_o,
  output logic          free_o,
  output logic          credit_o
);

  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic do_pop;

  assign empty_o    = (count_q == '0);
  assign free_o     = (count_q != CNT_W'(DEPTH));
  assign do_pop     = pop_i && !empty_o;
  assign credit_o   = do_pop;
  assign pop_data_o = mem[rd_ptr_q];

  // Storage only, entries past the count are never read
  always_ff @(posedge clk) begin
    if (push_i) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  // Pointers wrap at DEPTH, which need not be a power of two
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= (wr_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_pop) begin
        rd_ptr_q <= (rd_ptr_q == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(do_pop);
    end
  end

  // Writer spent a credit it did not have
  a_no_push_when_full: assert property (
    @(posedge clk) disable iff (!rst_n) push_i |-> free_o
  ) else $error("credit fifo overflow");

endmodule

`default_nettype wire

// ==== source/mdu_divider.sv ====
// Iterative radix-2 restoring divider on absolute values
// Normal latency DIV_STEPS+1 cycles, divide by zero and overflow 1 cycle
// Divide by zero gives all ones and the dividend as remainder
// Signed overflow gives the dividend and a zero remainder
`timescale 1ns/1ps
`default_nettype none

module mdu_divider
  import mdu_cfg_pkg::*, mdu_pipe_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire mdu_div_req_st req_i,
  output mdu_unit_rsp_st     rsp_o,
  output logic               busy_o
);

  logic                 running_q;
  logic [DIV_CNT_W-1:0] step_q;
  logic [XLEN-1:0]      rem_q, quo_q, divisor_q;
  logic                 q_neg_q, r_neg_q, rem_sel_q, we_q;
  logic [PREG_W-1:0]    pdest_q;

  logic            dvd_neg, dvs_neg, div_zero, overflow, last_step;
  logic [XLEN-1:0] dvd_abs, dvs_abs, corner_result;
  logic [XLEN:0]   shifted, trial;
  logic [XLEN-1:0] rem_next, quo_next, quo_fix, rem_fix;

  // ==========================================================
  // Request side
  // ==========================================================
  assign dvd_neg  = req_i.is_signed & req_i.dividend[XLEN-1];
  assign dvs_neg  = req_i.is_signed & req_i.divisor[XLEN-1];
  assign dvd_abs  = dvd_neg ? -req_i.dividend : req_i.dividend;
  assign dvs_abs  = dvs_neg ? -req_i.divisor : req_i.divisor;
  assign div_zero = (req_i.divisor == '0);
  // Most negative value divided by minus one
  assign overflow = req_i.is_signed && (req_i.dividend == {1'b1, {(XLEN-1){1'b0}}})
                    && (req_i.divisor == '1);

  always_comb begin
    if (div_zero) begin
      corner_result = req_i.rem_sel ? req_i.dividend : '1;
    end else begin
      corner_result = req_i.rem_sel ? '0 : req_i.dividend;
    end
  end

  // One restoring step, dividend bits shift out of the quotient register
  assign shifted = {rem_q, quo_q[XLEN-1]};
  assign trial   = shifted - {1'b0, divisor_q};

  always_comb begin
    if (!trial[XLEN]) begin
      rem_next = trial[XLEN-1:0];
      quo_next = {quo_q[XLEN-2:0], 1'b1};
    end else begin
      rem_next = shifted[XLEN-1:0];
      quo_next = {quo_q[XLEN-2:0], 1'b0};
    end
  end

  // Sign fix-up merged with the last step
  assign quo_fix   = q_neg_q ? -quo_next : quo_next;
  assign rem_fix   = r_neg_q ? -rem_next : rem_next;
  assign last_step = running_q && (step_q == DIV_CNT_W'(DIV_STEPS - 1));

  // ==========================================================
  // Control and response
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      running_q <= 1'b0;
      step_q    <= '0;
      rsp_o     <= '0;
    end else begin
      rsp_o.valid <= 1'b0;
      if (req_i.valid && (div_zero || overflow)) begin
        rsp_o.valid  <= 1'b1;
        rsp_o.result <= corner_result;
        rsp_o.pdest  <= req_i.pdest;
        rsp_o.we     <= req_i.pdest_valid;
      end else if (req_i.valid) begin
        running_q <= 1'b1;
        step_q    <= '0;
      end else if (last_step) begin
        running_q    <= 1'b0;
        rsp_o.valid  <= 1'b1;
        rsp_o.result <= rem_sel_q ? rem_fix : quo_fix;
        rsp_o.pdest  <= pdest_q;
        rsp_o.we     <= we_q;
      end else if (running_q) begin
        step_q <= step_q + 1'b1;
      end
    end
  end

  // Working registers
  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      rem_q     <= '0;
      quo_q     <= dvd_abs;
      divisor_q <= dvs_abs;
      // Quotient negative on differing signs, remainder follows dividend
      q_neg_q   <= dvd_neg ^ dvs_neg;
      r_neg_q   <= dvd_neg;
      rem_sel_q <= req_i.rem_sel;
      pdest_q   <= req_i.pdest;
      we_q      <= req_i.pdest_valid;
    end else if (running_q) begin
      rem_q <= rem_next;
      quo_q <= quo_next;
    end
  end

  assign busy_o = running_q;

  a_no_req_when_busy: assert property (
    @(posedge clk) disable iff (!rst_n) req_i.valid |-> !busy_o
  ) else $error("divider request while busy");

endmodule

`default_nettype wire

// ==== source/mdu_multiplier.sv ====
// Two-stage 33x33 signed multiplier, response 2 cycles after the request
// Signed flags choose sign or zero extension of each operand
`timescale 1ns/1ps
`default_nettype none

module mdu_multiplier
  import mdu_cfg_pkg::*, mdu_pipe_pkg::*;
(
  input  wire logic          clk,
  input  wire logic          rst_n,
  input  wire mdu_mul_req_st req_i,
  output mdu_unit_rsp_st     rsp_o,
  output logic               busy_o
);

  logic signed [XLEN:0]     op_a, op_b;
  logic signed [2*XLEN+1:0] product;

  logic                    s1_valid_q;
  logic [2*XLEN-1:0]       s1_prod_q;
  logic                    s1_high_q;
  logic [PREG_W-1:0]       s1_pdest_q;
  logic                    s1_we_q;

  // Extension bit is the top operand bit only for signed sources
  assign op_a    = {req_i.a_signed & req_i.src_a[XLEN-1], req_i.src_a};
  assign op_b    = {req_i.b_signed & req_i.src_b[XLEN-1], req_i.src_b};
  assign product = op_a * op_b;

  // ==========================================================
  // Stage one, product register
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= req_i.valid;
    end
  end

  always_ff @(posedge clk) begin
    if (req_i.valid) begin
      s1_prod_q  <= product[2*XLEN-1:0];
      s1_high_q  <= req_i.high_sel;
      s1_pdest_q <= req_i.pdest;
      s1_we_q    <= req_i.pdest_valid;
    end
  end

  // Stage two, word select into the response
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rsp_o <= '0;
    end else begin
      rsp_o.valid  <= s1_valid_q;
      rsp_o.result <= s1_high_q ? s1_prod_q[2*XLEN-1:XLEN] : s1_prod_q[XLEN-1:0];
      rsp_o.pdest  <= s1_pdest_q;
      rsp_o.we     <= s1_we_q;
    end
  end

  // In flight between request and response
  assign busy_o = s1_valid_q;

endmodule

`default_nettype wire

// ==== source/mdu_op_decode.sv ====
// Buffers issued operations and turns the head into one unit request
// Dispatch needs idle units and a reserved writeback slot (unit_grant_i)
// One operation in flight at a time keeps results in issue order
`timescale 1ns/1ps
`default_nettype none

module mdu_op_decode
  import mdu_cfg_pkg::*, mdu_pipe_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire mdu_issue_st issue_i,
  output logic             issue_credit_o,
  input  wire logic        units_idle_i,
  input  wire logic        unit_grant_i,
  output mdu_mul_req_st    mul_req_o,
  output mdu_div_req_st    div_req_o
);

  mdu_issue_st head;
  logic empty;
  logic dispatch;

  // Input queue, a credit goes back to the issuer on each pop
  mdu_credit_fifo #(
    .payload_t (mdu_issue_st),
    .DEPTH     (ISSUE_CREDITS)
  ) u_issue_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (issue_i.valid),
    .push_data_i (issue_i),
    .pop_i       (dispatch),
    .pop_data_o  (head),
    .empty_o     (empty),
    .free_o      (),
    .credit_o    (issue_credit_o)
  );

  assign dispatch = !empty && units_idle_i && unit_grant_i;

  // Op to unit request mapping
  always_comb begin
    mul_req_o = '0;
    div_req_o = '0;
    if (dispatch) begin
      case (head.op)
        MDU_MUL, MDU_MULH, MDU_MULHSU, MDU_MULHU: begin
          mul_req_o.valid       = 1'b1;
          // Low word is the same for any extension
          mul_req_o.a_signed    = head.op inside {MDU_MULH, MDU_MULHSU};
          mul_req_o.b_signed    = (head.op == MDU_MULH);
          mul_req_o.high_sel    = (head.op != MDU_MUL);
          mul_req_o.src_a       = head.src0;
          mul_req_o.src_b       = head.src1;
          mul_req_o.pdest       = head.pdest;
          mul_req_o.pdest_valid = head.pdest_valid;
        end
        default: begin
          div_req_o.valid       = 1'b1;
          div_req_o.is_signed   = head.op inside {MDU_DIV, MDU_REM};
          div_req_o.rem_sel     = head.op inside {MDU_REM, MDU_REMU};
          div_req_o.dividend    = head.src0;
          div_req_o.divisor     = head.src1;
          div_req_o.pdest       = head.pdest;
          div_req_o.pdest_valid = head.pdest_valid;
        end
      endcase
    end
  end

  // A dispatched op must raise busy or drop the grant in the next cycle
  a_one_in_flight: assert property (
    @(posedge clk) disable iff (!rst_n) dispatch |=> !dispatch
  ) else $error("unit request while an operation is in flight");

endmodule

`default_nettype wire

// ==== source/mdu_pipe.sv ====
// Multiply/divide pipe top, credit flow control on issue and writeback
// No flush, one operation executes at a time
`timescale 1ns/1ps
`default_nettype none

module mdu_pipe
  import mdu_pipe_pkg::*;
(
  input  wire logic        clk,
  input  wire logic        rst_n,
  input  wire mdu_issue_st issue_i,
  output logic             issue_credit_o,
  output mdu_wb_st         wb_o,
  input  wire logic        wb_credit_i
);

  mdu_mul_req_st  mul_req;
  mdu_div_req_st  div_req;
  mdu_unit_rsp_st mul_rsp, div_rsp;
  logic           mul_busy, div_busy;
  logic           units_idle;
  logic           unit_grant;

  assign units_idle = ~(mul_busy | div_busy);

  // ==========================================================
  // Decode
  // ==========================================================
  mdu_op_decode u_decode (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_i        (issue_i),
    .issue_credit_o (issue_credit_o),
    .units_idle_i   (units_idle),
    .unit_grant_i   (unit_grant),
    .mul_req_o      (mul_req),
    .div_req_o      (div_req)
  );

  // Execute units
  mdu_multiplier u_mul (
    .clk    (clk),
    .rst_n  (rst_n),
    .req_i  (mul_req),
    .rsp_o  (mul_rsp),
    .busy_o (mul_busy)
  );

  mdu_divider u_div (
    .clk    (clk),
    .rst_n  (rst_n),
    .req_i  (div_req),
    .rsp_o  (div_rsp),
    .busy_o (div_busy)
  );

  // Writeback
  mdu_result_stage u_result (
    .clk          (clk),
    .rst_n        (rst_n),
    .mul_rsp_i    (mul_rsp),
    .div_rsp_i    (div_rsp),
    .unit_grant_o (unit_grant),
    .wb_o         (wb_o),
    .wb_credit_i  (wb_credit_i)
  );

endmodule

`default_nettype wire

// ==== source/mdu_pipe_pkg.sv ====
// Payloads passed between the stages of the multiply/divide pipe
// The valid bit of every struct is its leading field
`default_nettype none

package mdu_pipe_pkg;
  import mdu_cfg_pkg::*;

  // ==========================================================
  // Issue queue entry
  // ==========================================================
  typedef struct packed {
    logic              valid;
    mdu_op_e           op;
    logic [XLEN-1:0]   src0;
    logic [XLEN-1:0]   src1;
    logic [PREG_W-1:0] pdest;
    logic              pdest_valid;
  } mdu_issue_st;

  // Multiplier request, sign bits pick the 33 bit extension
  typedef struct packed {
    logic              valid;
    logic              a_signed;
    logic              b_signed;
    // High word of the 64 bit product
    logic              high_sel;
    logic [XLEN-1:0]   src_a;
    logic [XLEN-1:0]   src_b;
    logic [PREG_W-1:0] pdest;
    logic              pdest_valid;
  } mdu_mul_req_st;

  // Divider request
  typedef struct packed {
    logic              valid;
    logic              is_signed;
    // Return remainder instead of quotient
    logic              rem_sel;
    logic [XLEN-1:0]   dividend;
    logic [XLEN-1:0]   divisor;
    logic [PREG_W-1:0] pdest;
    logic              pdest_valid;
  } mdu_div_req_st;

  // Common response of both execute units
  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   result;
    logic [PREG_W-1:0] pdest;
    logic              we;
  } mdu_unit_rsp_st;

  // ==========================================================
  // Writeback entry
  // ==========================================================
  typedef struct packed {
    logic              valid;
    logic              we;
    logic [PREG_W-1:0] pdest;
    logic [XLEN-1:0]   wdata;
  } mdu_wb_st;

endpackage

`default_nettype wire

// ==== source/mdu_result_stage.sv ====
// Merges unit responses into writeback entries
// unit_grant_o reserves a queue slot for the next operation
// wb_o is registered and valid for one cycle per spent credit
`timescale 1ns/1ps
`default_nettype none

module mdu_result_stage
  import mdu_cfg_pkg::*, mdu_pipe_pkg::*;
(
  input  wire logic           clk,
  input  wire logic           rst_n,
  input  wire mdu_unit_rsp_st mul_rsp_i,
  input  wire mdu_unit_rsp_st div_rsp_i,
  output logic                unit_grant_o,
  output mdu_wb_st            wb_o,
  input  wire logic           wb_credit_i
);

  mdu_unit_rsp_st       rsp_sel;
  mdu_wb_st             push_entry, head;
  logic                 push, pop, popped, empty, free;
  logic [WB_CNT_W-1:0]  credits_q;

  // At most one unit answers per cycle
  assign rsp_sel = mul_rsp_i.valid ? mul_rsp_i : div_rsp_i;
  assign push    = mul_rsp_i.valid | div_rsp_i.valid;

  always_comb begin
    push_entry       = '0;
    push_entry.valid = 1'b1;
    push_entry.we    = rsp_sel.we;
    push_entry.pdest = rsp_sel.pdest;
    push_entry.wdata = rsp_sel.result;
  end

  mdu_credit_fifo #(
    .payload_t (mdu_wb_st),
    .DEPTH     (WB_QUEUE_DEPTH)
  ) u_wb_fifo (
    .clk         (clk),
    .rst_n       (rst_n),
    .push_i      (push),
    .push_data_i (push_entry),
    .pop_i       (pop),
    .pop_data_o  (head),
    .empty_o     (empty),
    .free_o      (free),
    .credit_o    (popped)
  );

  // A response landing this cycle still holds its slot in the count
  assign unit_grant_o = free && !push;
  assign pop          = !empty && (credits_q != '0);

  // ==========================================================
  // Writeback credits and output register
  // ==========================================================
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits_q <= WB_CNT_W'(WB_CREDITS);
      wb_o      <= '0;
    end else begin
      credits_q <= credits_q - WB_CNT_W'(popped) + WB_CNT_W'(wb_credit_i);
      wb_o      <= popped ? head : '0;
    end
  end

  // Consumer returned more credits than it was granted
  a_credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n) credits_q <= WB_CNT_W'(WB_CREDITS)
  ) else $error("writeback credit count above limit");

endmodule

`default_nettype wire

// ==== verif/mdu_pipe_tb.sv ====
// Testbench for the multiply/divide pipe
// Issue and writeback credits are modelled on the testbench side
// Writeback credits come back at random, so results see back-pressure
// Inputs change 10 ns after the rising edge, outputs sampled on the falling edge
`timescale 1ns/1ps
`default_nettype none

module mdu_pipe_tb
  import mdu_cfg_pkg::*, mdu_pipe_pkg::*;
();

  typedef struct {
    mdu_op_e           op;
    logic [XLEN-1:0]   src0;
    logic [XLEN-1:0]   src1;
    logic [PREG_W-1:0] pdest;
    logic              pdest_valid;
    logic [XLEN-1:0]   exp_wdata;
  } case_t;

  logic        clk;
  logic        rst_n;
  mdu_issue_st issue_i;
  logic        issue_credit_o;
  mdu_wb_st    wb_o;
  logic        wb_credit_i;

  case_t table_q[$];
  int    exp_q[$];
  int    issue_credits, issued, credit_pulses;
  int    received, wb_returned, wb_pending;
  int    cycles, limit;

  mdu_pipe uut (
    .clk            (clk),
    .rst_n          (rst_n),
    .issue_i        (issue_i),
    .issue_credit_o (issue_credit_o),
    .wb_o           (wb_o),
    .wb_credit_i    (wb_credit_i)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ==========================================================
  // Reference model and checks
  // ==========================================================
  function automatic logic [XLEN-1:0] ref_result(input mdu_op_e op,
      input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
    longint            sa, sb;
    longint unsigned   ua, ub;
    int                ia, ib;
    logic [2*XLEN-1:0] prod;
    logic              ovf;
    logic [XLEN-1:0]   res;
    sa  = $signed(a);
    sb  = $signed(b);
    ua  = a;
    ub  = b;
    ia  = a;
    ib  = b;
    ovf = (a == {1'b1, {(XLEN-1){1'b0}}}) && (b == '1);
    res = '0;
    case (op)
      MDU_MUL: begin
        prod = ua * ub;
        res  = prod[XLEN-1:0];
      end
      MDU_MULH: begin
        prod = sa * sb;
        res  = prod[2*XLEN-1:XLEN];
      end
      MDU_MULHSU: begin
        // Zero-extended b fits a signed 64 bit value
        prod = sa * longint'(ub);
        res  = prod[2*XLEN-1:XLEN];
      end
      MDU_MULHU: begin
        prod = ua * ub;
        res  = prod[2*XLEN-1:XLEN];
      end
      MDU_DIV:  res = (b == '0) ? -1 : (ovf ? ia : ia / ib);
      MDU_DIVU: res = (b == '0) ? '1 : a / b;
      // Remainder takes the dividend's sign, as the % operator does
      MDU_REM:  res = (b == '0) ? ia : (ovf ? 0 : ia % ib);
      MDU_REMU: res = (b == '0) ? a : a % b;
      default:  res = '0;
    endcase
    return res;
  endfunction

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("Test failures found");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [XLEN-1:0] expected,
      input logic [XLEN-1:0] actual);
    if (actual !== expected) begin
      abort_run($sformatf("Mismatch in %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic add_case(input mdu_op_e op, input logic [XLEN-1:0] a,
      input logic [XLEN-1:0] b, input logic pv);
    case_t c;
    c.op          = op;
    c.src0        = a;
    c.src1        = b;
    c.pdest       = PREG_W'(table_q.size() + 1);
    c.pdest_valid = pv;
    c.exp_wdata   = ref_result(op, a, b);
    table_q.push_back(c);
  endtask

  // One writeback beat against the head of the in-order model
  task automatic score_writeback();
    int    idx;
    string name;
    if (exp_q.size() == 0) begin
      abort_run("Writeback arrived with no operation outstanding");
    end
    idx = exp_q.pop_front();
    name = $sformatf("case %0d %s", idx, table_q[idx].op.name());
    received++;
    if (received > WB_CREDITS + wb_returned) begin
      abort_run("More writeback beats than writeback credits granted");
    end
    check_equal({name, " wdata"}, table_q[idx].exp_wdata, wb_o.wdata);
    check_equal({name, " pdest"}, XLEN'(table_q[idx].pdest), XLEN'(wb_o.pdest));
    check_equal({name, " we"}, XLEN'(table_q[idx].pdest_valid), XLEN'(wb_o.we));
    wb_pending++;
  endtask

  // ==========================================================
  // Output monitor, falling edge
  // ==========================================================
  initial begin
    forever begin
      @(negedge clk);
      cycles++;
      if (cycles > limit) begin
        abort_run($sformatf("Timeout after %0d cycles, %0d of %0d results seen",
                            cycles, received, table_q.size()));
      end
      // Quiet outputs until the first issue
      if (issued == 0) begin
        check_equal("idle issue credit", '0, XLEN'(issue_credit_o));
        check_equal("idle wb valid", '0, XLEN'(wb_o.valid));
      end
      if (issue_credit_o) begin
        credit_pulses++;
        issue_credits++;
      end
      if (credit_pulses > issued) begin
        abort_run("Issue credit returned for an operation never issued");
      end
      if (wb_o.valid) begin
        score_writeback();
      end
    end
  end

  // ==========================================================
  // Stimulus
  // ==========================================================
  initial begin
    int idx;
    void'($urandom(82));
    issue_i       = '0;
    wb_credit_i   = 1'b0;
    rst_n         = 1'b0;
    issue_credits = ISSUE_CREDITS;

    // Directed multiplies, mixed signs
    add_case(MDU_MUL, 32'd7, 32'd6, 1'b1);
    add_case(MDU_MUL, -32'sd3, 32'd5, 1'b1);
    add_case(MDU_MUL, 32'h7fffffff, 32'd2, 1'b1);
    add_case(MDU_MUL, 32'hffffffff, 32'hffffffff, 1'b1);
    add_case(MDU_MULH, 32'h80000000, 32'h80000000, 1'b1);
    add_case(MDU_MULH, -32'sd2, 32'd3, 1'b1);
    add_case(MDU_MULH, 32'h12345678, 32'h9abcdef0, 1'b1);
    add_case(MDU_MULHSU, 32'hffffffff, 32'hffffffff, 1'b1);
    add_case(MDU_MULHSU, 32'h40000000, 32'hfffffff0, 1'b1);
    add_case(MDU_MULHU, 32'hffffffff, 32'hffffffff, 1'b1);
    add_case(MDU_MULHU, 32'h12345678, 32'h9abcdef0, 1'b1);
    // Divides, all sign combinations
    add_case(MDU_DIV, 32'd100, 32'd7, 1'b1);
    add_case(MDU_DIV, -32'sd100, 32'd7, 1'b1);
    add_case(MDU_DIV, 32'd100, -32'sd7, 1'b1);
    add_case(MDU_DIV, -32'sd100, -32'sd7, 1'b1);
    add_case(MDU_DIVU, 32'hffffffff, 32'd3, 1'b1);
    add_case(MDU_REM, -32'sd100, 32'd7, 1'b1);
    add_case(MDU_REM, 32'd100, -32'sd7, 1'b1);
    add_case(MDU_REMU, 32'hffffffff, 32'd10, 1'b1);
    // Divide by zero and signed overflow
    add_case(MDU_DIV, 32'd5, 32'd0, 1'b1);
    add_case(MDU_DIVU, 32'd7, 32'd0, 1'b1);
    add_case(MDU_REM, 32'd5, 32'd0, 1'b1);
    add_case(MDU_REMU, 32'd9, 32'd0, 1'b1);
    add_case(MDU_DIV, 32'h80000000, 32'hffffffff, 1'b1);
    add_case(MDU_REM, 32'h80000000, 32'hffffffff, 1'b1);
    // No destination, still retires
    add_case(MDU_MUL, 32'd3, 32'd4, 1'b0);
    add_case(MDU_DIV, 32'd20, 32'd4, 1'b0);
    // Random ops, small divisors now and then
    repeat (8) begin
      add_case(mdu_op_e'($urandom % 8), $urandom,
               ($urandom % 2) ? $urandom : $urandom % 4, 1'b1);
    end
    limit = 16 + table_q.size() * (DIV_STEPS + 10);

    repeat (16) @(posedge clk);
    #10;
    rst_n = 1'b1;

    idx = 0;
    while (idx < table_q.size() || received < table_q.size()) begin
      @(posedge clk);
      #10;
      issue_i     = '0;
      wb_credit_i = 1'b0;
      // Issue only with a credit in hand, with random gaps
      if (idx < table_q.size() && issue_credits > 0 && ($urandom % 4 != 0)) begin
        issue_i.valid       = 1'b1;
        issue_i.op          = table_q[idx].op;
        issue_i.src0        = table_q[idx].src0;
        issue_i.src1        = table_q[idx].src1;
        issue_i.pdest       = table_q[idx].pdest;
        issue_i.pdest_valid = table_q[idx].pdest_valid;
        exp_q.push_back(idx);
        issue_credits--;
        issued++;
        idx++;
      end
      // Consumer hands slots back at random
      if (wb_pending > 0 && ($urandom % 3 == 0)) begin
        wb_credit_i = 1'b1;
        wb_pending--;
        wb_returned++;
      end
    end

    @(posedge clk);
    #10;
    issue_i     = '0;
    wb_credit_i = 1'b0;
    check_equal("issue credit pulses", XLEN'(issued), XLEN'(credit_pulses));
    check_equal("results outstanding", '0, XLEN'(exp_q.size()));
    $display("All tests passed!");
    $finish;
  end

endmodule

`default_nettype wire
